//--- design/srt_divider_config.svh
// srt divider configuration for operand width, stage count, table indexing and latency
`ifndef SRT_DIVIDER_CONFIG_SVH
`define SRT_DIVIDER_CONFIG_SVH

`define DIV_WIDTH 32

// two quotient bits per stage
`define DIV_STAGES 16

`define DIV_SHIFT_WIDTH 5

`define DIV_TABLE_B_BITS 3
`define DIV_TABLE_P_BITS 6

`define DIV_LATENCY 17

`endif

//--- design/srt_divider_pkg.sv
// srt divider types shared by the normalizer, the iteration stages and the output logic
`default_nettype none
`include "srt_divider_config.svh"

package srt_divider_pkg;

    typedef logic [`DIV_WIDTH-1:0] word_t;

    // {signed remainder[32:0], unused dividend bits[31:0]}
    typedef logic [2*`DIV_WIDTH:0] prem_t;

    typedef enum logic [2:0] {
        two_n,
        one_n,
        zero,
        one_p,
        two_p,
        invalid
    } digit_t;

    typedef struct packed {
        logic                        valid;
        logic                        div_zero;
        logic [`DIV_SHIFT_WIDTH-1:0] shift;
        word_t                       divisor;
        prem_t                       prem;
        word_t                       quotient;
    } div_state_t;

endpackage

`default_nettype wire

//--- design/srt_normalize.sv
// srt normalizer that finds the divisor's leading one and shifts both operands by that count
`default_nettype none
`include "srt_divider_config.svh"

module srt_normalize (
    input  srt_divider_pkg::word_t       dividend,
    input  srt_divider_pkg::word_t       divisor,
    output srt_divider_pkg::prem_t       prem,
    output srt_divider_pkg::word_t       norm_divisor,
    output logic [`DIV_SHIFT_WIDTH-1:0]  shift,
    output logic                         div_zero
);
    import srt_divider_pkg::*;

    prem_t dividend_ext;

    assign dividend_ext = prem_t'(dividend);
    assign div_zero = (divisor == '0);

    // ascending scan so the highest set bit wins
    always_comb begin
        shift = '0;
        for (int i = 0; i < `DIV_WIDTH; i++) begin
            if (divisor[i]) begin
                shift = `DIV_SHIFT_WIDTH'(`DIV_WIDTH - 1 - i);
            end
        end
    end

    always_comb begin
        if (div_zero) begin
            prem = '0;
            norm_divisor = '0;
        end else begin
            prem = dividend_ext << shift;
            norm_divisor = divisor << shift;
        end
    end

endmodule

`default_nettype wire

//--- design/srt_digit_select.sv
// srt quotient-digit table indexed by divisor range and remainder estimate
`default_nettype none
`include "srt_divider_config.svh"

module srt_digit_select (
    input  logic [`DIV_TABLE_B_BITS-1:0] divisor_bits,
    input  logic [`DIV_TABLE_P_BITS-1:0] prem_bits,
    output srt_divider_pkg::digit_t      digit
);
    import srt_divider_pkg::*;

    logic signed [`DIV_TABLE_P_BITS-1:0] est;

    // row bounds as lowest valid, first -1, first 0, first +1, first +2 and highest valid
    logic signed [`DIV_TABLE_P_BITS-1:0] lo;
    logic signed [`DIV_TABLE_P_BITS-1:0] n1;
    logic signed [`DIV_TABLE_P_BITS-1:0] z0;
    logic signed [`DIV_TABLE_P_BITS-1:0] p1;
    logic signed [`DIV_TABLE_P_BITS-1:0] p2;
    logic signed [`DIV_TABLE_P_BITS-1:0] hi;

    assign est = $signed(prem_bits);

    always_comb begin
        unique case (divisor_bits)
            3'b000: begin
                {lo, n1, z0, p1, p2, hi} = {-6'sd12, -6'sd6, -6'sd2, 6'sd2, 6'sd6, 6'sd11};
            end
            3'b001: begin
                {lo, n1, z0, p1, p2, hi} = {-6'sd14, -6'sd7, -6'sd2, 6'sd3, 6'sd7, 6'sd13};
            end
            3'b010: begin
                {lo, n1, z0, p1, p2, hi} = {-6'sd15, -6'sd8, -6'sd2, 6'sd3, 6'sd8, 6'sd14};
            end
            3'b011: begin
                {lo, n1, z0, p1, p2, hi} = {-6'sd16, -6'sd8, -6'sd2, 6'sd3, 6'sd9, 6'sd15};
            end
            3'b100: begin
                {lo, n1, z0, p1, p2, hi} = {-6'sd18, -6'sd9, -6'sd3, 6'sd4, 6'sd10, 6'sd17};
            end
            3'b101: begin
                {lo, n1, z0, p1, p2, hi} = {-6'sd19, -6'sd10, -6'sd3, 6'sd4, 6'sd10, 6'sd18};
            end
            3'b110: begin
                {lo, n1, z0, p1, p2, hi} = {-6'sd20, -6'sd10, -6'sd3, 6'sd4, 6'sd11, 6'sd19};
            end
            3'b111: begin
                {lo, n1, z0, p1, p2, hi} = {-6'sd22, -6'sd11, -6'sd3, 6'sd5, 6'sd12, 6'sd21};
            end
        endcase
    end

    always_comb begin
        if (est < lo || est > hi) begin
            digit = invalid;
        end else if (est < n1) begin
            digit = two_n;
        end else if (est < z0) begin
            digit = one_n;
        end else if (est < p1) begin
            digit = zero;
        end else if (est < p2) begin
            digit = one_p;
        end else begin
            digit = two_p;
        end
    end

endmodule

`default_nettype wire

//--- design/srt_stage.sv
// srt iteration stage that does one registered radix-4 step on the partial remainder and quotient
`default_nettype none
`include "srt_divider_config.svh"

module srt_stage (
    input  logic                        clk,
    input  logic                        reset,
    input  srt_divider_pkg::div_state_t state_in,
    output srt_divider_pkg::div_state_t state_out
);
    import srt_divider_pkg::*;

    digit_t     digit;
    div_state_t state_next;
    logic [34:0] shifted;
    logic [34:0] div_ext;
    logic [34:0] rem_next;

    srt_digit_select i_srt_digit_select (
        .divisor_bits (state_in.divisor[`DIV_WIDTH-2 -: `DIV_TABLE_B_BITS]),
        .prem_bits    (state_in.prem[2*`DIV_WIDTH -: `DIV_TABLE_P_BITS]),
        .digit        (digit)
    );

    // 4 * remainder plus the next two dividend bits with the sign in bit 34
    assign shifted = state_in.prem[2*`DIV_WIDTH:`DIV_WIDTH-2];
    assign div_ext = {3'b000, state_in.divisor};

    always_comb begin
        state_next = state_in;
        case (digit)
            two_p: begin
                rem_next = shifted - (div_ext << 1);
                state_next.quotient = {state_in.quotient[29:0], 2'b10};
            end
            one_p: begin
                rem_next = shifted - div_ext;
                state_next.quotient = {state_in.quotient[29:0], 2'b01};
            end
            one_n: begin
                rem_next = shifted + div_ext;
                state_next.quotient = {state_in.quotient[29:0] - 30'd1, 2'b11};
            end
            two_n: begin
                rem_next = shifted + (div_ext << 1);
                state_next.quotient = {state_in.quotient[29:0] - 30'd1, 2'b10};
            end
            default: begin
                rem_next = shifted;
                state_next.quotient = {state_in.quotient[29:0], 2'b00};
            end
        endcase
        state_next.prem = {rem_next[32:0], state_in.prem[29:0], 2'b00};
    end

    always_ff @(posedge clk) begin
        state_out <= state_next;
        if (reset) begin
            state_out.valid <= 1'b0;
        end
    end

    // remainder must stay inside the table's convergence band
    assert property (@(posedge clk) disable iff (reset)
        state_in.valid && !state_in.div_zero |-> digit != invalid);

endmodule

`default_nettype wire

//--- design/srt_finish.sv
// srt output stage for remainder correction, un-normalization and bypass results
`default_nettype none
`include "srt_divider_config.svh"

module srt_finish (
    input  srt_divider_pkg::div_state_t state,
    output logic                        ok,
    output srt_divider_pkg::word_t      quotient,
    output srt_divider_pkg::word_t      remainder
);
    import srt_divider_pkg::*;

    logic [`DIV_WIDTH:0] rem_raw;
    logic [`DIV_WIDTH:0] rem_fixed;
    word_t               quo_fixed;

    assign rem_raw = state.prem[2*`DIV_WIDTH:`DIV_WIDTH];
    assign ok = state.valid;

    // a negative remainder means one divisor too many was taken
    always_comb begin
        if (rem_raw[`DIV_WIDTH]) begin
            rem_fixed = rem_raw + {1'b0, state.divisor};
            quo_fixed = state.quotient - word_t'(1);
        end else begin
            rem_fixed = rem_raw;
            quo_fixed = state.quotient;
        end
    end

    // bypass ops carry the dividend in the divisor field
    // nonzero shift there marks a divisor of one
    always_comb begin
        if (state.div_zero && state.shift != '0) begin
            quotient = state.divisor;
            remainder = '0;
        end else if (state.div_zero) begin
            quotient = '1;
            remainder = state.divisor;
        end else begin
            quotient = quo_fixed;
            remainder = rem_fixed[`DIV_WIDTH-1:0] >> state.shift;
        end
    end

endmodule

`default_nettype wire

//--- design/srt_divider.sv
// srt divider top level for pipelined unsigned radix-4 division at one operation per clock
`default_nettype none
`include "srt_divider_config.svh"

module srt_divider (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   valid,
    input  srt_divider_pkg::word_t dividend,
    input  srt_divider_pkg::word_t divisor,
    output logic                   ok,
    output srt_divider_pkg::word_t quotient,
    output srt_divider_pkg::word_t remainder
);
    import srt_divider_pkg::*;

    logic                        valid_q;
    word_t                       dividend_q;
    word_t                       divisor_q;
    prem_t                       norm_prem;
    word_t                       norm_divisor;
    logic [`DIV_SHIFT_WIDTH-1:0] norm_shift;
    logic                        norm_zero;
    logic                        bypass;
    div_state_t                  state [`DIV_STAGES+1];

    always_ff @(posedge clk) begin
        dividend_q <= dividend;
        divisor_q <= divisor;
        if (reset) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= valid;
        end
    end

    srt_normalize i_srt_normalize (
        .dividend     (dividend_q),
        .divisor      (divisor_q),
        .prem         (norm_prem),
        .norm_divisor (norm_divisor),
        .shift        (norm_shift),
        .div_zero     (norm_zero)
    );

    // a quotient above 2/3 of 2^32 is out of reach of the digit set,
    // so divide by one skips the iteration like divide by zero
    assign bypass = norm_zero || (divisor_q == word_t'(1));

    always_ff @(posedge clk) begin
        state[0].div_zero <= bypass;
        state[0].shift <= norm_shift;
        state[0].divisor <= bypass ? dividend_q : norm_divisor;
        state[0].prem <= bypass ? '0 : norm_prem;
        state[0].quotient <= '0;
        if (reset) begin
            state[0].valid <= 1'b0;
        end else begin
            state[0].valid <= valid_q;
        end
    end

    for (genvar i = 0; i < `DIV_STAGES; i++) begin : g_stage
        srt_stage i_srt_stage (
            .clk       (clk),
            .reset     (reset),
            .state_in  (state[i]),
            .state_out (state[i+1])
        );
    end

    srt_finish i_srt_finish (
        .state     (state[`DIV_STAGES]),
        .ok        (ok),
        .quotient  (quotient),
        .remainder (remainder)
    );

    // ok is seen one edge after the 17th register captures the op
    assert property (@(posedge clk) disable iff (reset)
        valid |-> ##(`DIV_LATENCY + 1) ok);

endmodule

`default_nettype wire

//--- test/tb_srt_divider.sv
// srt divider testbench with random and directed divisions checked against a reference queue
`default_nettype none
`include "srt_divider_config.svh"

module tb_srt_divider;
    timeunit 1ns;
    timeprecision 100ps;

    import srt_divider_pkg::*;

    localparam int CLK_PERIOD = 100;
    localparam int RESET_CYCLES = 10;
    localparam int NUM_RANDOM = 2000;
    localparam int NUM_SINGLE = 10;
    localparam int NUM_BURST = 200;
    localparam int NUM_CORNER = 2 * `DIV_WIDTH + 8;
    localparam int NUM_ZERO = 48;
    localparam int NUM_FLUSHED = 30;
    localparam int TOTAL_OPS = NUM_RANDOM + NUM_SINGLE + NUM_BURST
                             + NUM_CORNER + NUM_ZERO + 2 * NUM_FLUSHED;
    // result shows at the falling edge after the last stage register
    localparam int OK_DELAY = `DIV_LATENCY + 1;

    logic  clk;
    logic  reset;
    logic  valid;
    word_t dividend;
    word_t divisor;
    logic  ok;
    word_t quotient;
    word_t remainder;

    word_t exp_quotient [$];
    word_t exp_remainder [$];
    int    exp_due [$];
    int    cycle;
    int    value_errors;
    int    other_errors;

    srt_divider i_srt_divider (
        .clk       (clk),
        .reset     (reset),
        .valid     (valid),
        .dividend  (dividend),
        .divisor   (divisor),
        .ok        (ok),
        .quotient  (quotient),
        .remainder (remainder)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic check_word(input string name, input word_t actual, input word_t expected);
        if (actual !== expected) begin
            value_errors++;
            $display("CHECK FAILED at %0d ns: %s = %h, expected %h",
                     $time, name, actual, expected);
        end
    endtask

    task automatic check_flag(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            value_errors++;
            $display("CHECK FAILED at %0d ns: %s = %b, expected %b",
                     $time, name, actual, expected);
        end
    endtask

    task automatic report_problem(input string what);
        other_errors++;
        $display("ERROR at %0d ns: %s", $time, what);
    endtask

    // expected results by plain unsigned division, all ones and the dividend for a zero divisor
    task automatic push_expected(input word_t a, input word_t b);
        if (b == word_t'(0)) begin
            exp_quotient.push_back(~word_t'(0));
            exp_remainder.push_back(a);
        end else begin
            exp_quotient.push_back(a / b);
            exp_remainder.push_back(a % b);
        end
        exp_due.push_back(cycle + OK_DELAY);
    endtask

    task automatic check_outputs(input logic in_reset);
        if (in_reset) begin
            check_flag("ok", ok, 1'b0);
        end else if (exp_due.size() == 0) begin
            if (ok !== 1'b0) begin
                report_problem("ok asserted with no operation in flight");
            end
        end else if (exp_due[0] == cycle) begin
            check_flag("ok", ok, 1'b1);
            if (ok === 1'b1) begin
                check_word("quotient", quotient, exp_quotient[0]);
                check_word("remainder", remainder, exp_remainder[0]);
            end
            void'(exp_quotient.pop_front());
            void'(exp_remainder.pop_front());
            void'(exp_due.pop_front());
        end else begin
            check_flag("ok", ok, 1'b0);
        end
    endtask

    // outputs are checked at the falling edge before new inputs go out
    task automatic next_cycle();
        logic reset_sampled;
        reset_sampled = reset;
        @(negedge clk);
        cycle++;
        check_outputs(reset_sampled);
    endtask

    task automatic drive_op(input word_t a, input word_t b);
        next_cycle();
        valid = 1'b1;
        dividend = a;
        divisor = b;
        push_expected(a, b);
    endtask

    task automatic drive_idle();
        next_cycle();
        valid = 1'b0;
        dividend = $urandom;
        divisor = $urandom;
    endtask

    task automatic drain();
        repeat (OK_DELAY + 1) drive_idle();
    endtask

    task automatic apply_reset(input int cycles);
        next_cycle();
        reset = 1'b1;
        valid = 1'b0;
        // ops in flight are lost
        exp_quotient.delete();
        exp_remainder.delete();
        exp_due.delete();
        repeat (cycles) next_cycle();
        reset = 1'b0;
    endtask

    // spread divisor widths so short and long quotients both show up
    function automatic word_t random_divisor();
        return $urandom >> ($urandom % `DIV_WIDTH);
    endfunction

    initial begin
        #((TOTAL_OPS + 100) * 2 * CLK_PERIOD);
        $display("ERROR: watchdog expired before the tests completed");
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin
        word_t a;
        word_t b;
        void'($urandom(32'hcddc_337b));
        valid = 1'b0;
        dividend = '0;
        divisor = '0;
        reset = 1'b1;
        cycle = 0;
        value_errors = 0;
        other_errors = 0;

        @(posedge clk);
        repeat (RESET_CYCLES) next_cycle();
        reset = 1'b0;
        repeat (5) drive_idle();

        // random pairs with an idle cycle now and then
        for (int i = 0; i < NUM_RANDOM; i++) begin
            if ($urandom % 8 == 0) begin
                drive_idle();
            end
            drive_op($urandom, random_divisor());
        end
        drain();

        // isolated ops for latency
        for (int i = 0; i < NUM_SINGLE; i++) begin
            drive_op($urandom, random_divisor());
            repeat (OK_DELAY + $urandom % 4) drive_idle();
        end

        for (int i = 0; i < NUM_BURST; i++) begin
            drive_op($urandom, random_divisor());
        end
        drain();

        // corner divisors and dividends
        drive_op($urandom, word_t'(1));
        drive_op(~word_t'(0), word_t'(1));
        for (int i = 0; i < `DIV_WIDTH; i++) begin
            drive_op($urandom, word_t'(1) << i);
            drive_op(~word_t'(0), word_t'(1) << i);
        end
        drive_op($urandom, ~word_t'(0));
        drive_op(~word_t'(0), ~word_t'(0));
        for (int i = 0; i < 2; i++) begin
            a = $urandom >> 2;
            b = a + word_t'(1) + ($urandom >> 2);
            drive_op(a, b);
        end
        drive_op(word_t'(0), random_divisor() | word_t'(1));
        drive_op(word_t'(0), ~word_t'(0));
        drain();

        // zero divisors alone and mixed with normal ops
        drive_op($urandom, word_t'(0));
        drive_op(word_t'(0), word_t'(0));
        drive_op(~word_t'(0), word_t'(0));
        for (int i = 0; i < NUM_ZERO - 3; i++) begin
            drive_op($urandom, (i % 3 == 1) ? word_t'(0) : random_divisor());
        end
        drain();

        // reset with a full pipeline
        for (int i = 0; i < NUM_FLUSHED; i++) begin
            drive_op($urandom, random_divisor());
        end
        apply_reset(RESET_CYCLES);
        repeat (OK_DELAY + 2) drive_idle();
        for (int i = 0; i < NUM_FLUSHED; i++) begin
            drive_op($urandom, random_divisor());
        end
        drain();

        if (exp_due.size() != 0) begin
            report_problem($sformatf("%0d results never came out", exp_due.size()));
        end
        $display("errors: %0d value mismatches, %0d other failures",
                 value_errors, other_errors);
        if (value_errors + other_errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- srt_divider.f
+incdir+design
design/srt_divider_pkg.sv
design/srt_normalize.sv
design/srt_digit_select.sv
design/srt_stage.sv
design/srt_finish.sv
design/srt_divider.sv
test/tb_srt_divider.sv

//--- Makefile
TOP = tb_srt_divider
LOG = sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f srt_divider.f --top-module srt_divider

sim:
	verilator --binary --timing --assert -j 0 -f srt_divider.f \
		--top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "Simulation finished: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
